//--- ex_macros.svh
/*
 * widths, lane count, multiplier latency and completion queue sizing
 * shared by the execute stage; include wherever one of these is needed
 */

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// datapath and tag widths
`define EX_XLEN 32
`define EX_TAG_W 6

// multiplier pool
`define EX_MUL_NUM 2
`define EX_MUL_CYCLES 3

// completion queue
`define EX_CQ_DEPTH 8
// issue stops when fewer free entries than this remain
`define EX_CQ_HEADROOM 4

`endif

//--- ex_pkg.sv
/*
 * enums and packed structs carried between the execute stage blocks:
 * the issue packet, selected operands, result and predictor update
 */

`include "ex_macros.svh"

package ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		ALU,
		BR,
		MULT
	} ex_channel_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1,
		OPA_IS_PC,
		OPA_IS_ZERO
	} ex_opa_sel_e;

	typedef enum logic {
		OPB_IS_RS2,
		OPB_IS_IMM
	} ex_opb_sel_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_MUL,
		ALU_MULH,
		ALU_MULHSU,
		ALU_MULHU
	} ex_alu_func_e;

	////////////////////////////////////////////////////////////////////////////
	// packets
	////////////////////////////////////////////////////////////////////////////

	// one issued instruction, imm already sign-extended
	typedef struct packed {
		logic                 valid;
		ex_channel_e          channel;
		ex_opa_sel_e          opa_sel;
		ex_opb_sel_e          opb_sel;
		ex_alu_func_e         alu_func;
		logic [2:0]           funct3;
		logic                 cond_branch;
		logic                 uncond_branch;
		logic [`EX_XLEN-1:0]  pc;
		logic [`EX_XLEN-1:0]  pred_npc;
		logic [`EX_XLEN-1:0]  rs1_value;
		logic [`EX_XLEN-1:0]  rs2_value;
		logic [`EX_XLEN-1:0]  imm;
		logic [`EX_TAG_W-1:0] dest_tag;
	} ex_issue_pkt_t;

	// muxed operands plus the packet they came from
	typedef struct packed {
		logic [`EX_XLEN-1:0] opa;
		logic [`EX_XLEN-1:0] opb;
		ex_issue_pkt_t       pkt;
	} ex_op_t;

	typedef struct packed {
		logic                 valid;
		logic [`EX_XLEN-1:0]  pc;
		logic [`EX_XLEN-1:0]  pred_npc;
		logic [`EX_TAG_W-1:0] dest_tag;
		logic [`EX_XLEN-1:0]  result;
		logic                 take_branch;
		logic                 is_branch;
	} ex_result_pkt_t;

	// branch target buffer / predictor update
	typedef struct packed {
		logic                valid;
		logic [`EX_XLEN-1:0] pc;
		logic [`EX_XLEN-1:0] target_pc;
		logic                taken;
	} ex_btb_upd_t;

endpackage

//--- ex_operand_sel.sv
/*
 * input side of the execute stage: operand A/B muxes and the decode of
 * the packet's channel into one start strobe per functional path
 */

module ex_operand_sel
	import ex_pkg::*;
(
	input  ex_issue_pkt_t issue,
	output ex_op_t        op,
	output logic          alu_start,
	output logic          br_start,
	output logic          mul_start
);

	// operand A
	always_comb begin
		case (issue.opa_sel)
			OPA_IS_RS1: op.opa = issue.rs1_value;
			OPA_IS_PC:  op.opa = issue.pc;
			default:    op.opa = '0;
		endcase
	end

	// operand B
	always_comb begin
		case (issue.opb_sel)
			OPB_IS_IMM: op.opb = issue.imm;
			default:    op.opb = issue.rs2_value;
		endcase
	end

	assign op.pkt = issue;

	// at most one strobe, and only for a valid packet
	always_comb begin
		alu_start = 1'b0;
		br_start  = 1'b0;
		mul_start = 1'b0;
		if (issue.valid) begin
			case (issue.channel)
				ALU:     alu_start = 1'b1;
				BR:      br_start  = 1'b1;
				MULT:    mul_start = 1'b1;
				default: ;
			endcase
		end
	end

endmodule

//--- ex_alu_branch.sv
/*
 * single-cycle ALU and branch unit; the result packet is combinational
 * and valid in the same cycle as alu_start or br_start
 */

`include "ex_macros.svh"

module ex_alu_branch
	import ex_pkg::*;
(
	input  ex_op_t         op,
	input  logic           alu_start,
	input  logic           br_start,
	output ex_result_pkt_t result
);

	localparam int SHAMT_W = $clog2(`EX_XLEN);

	logic [`EX_XLEN-1:0] opa;
	logic [`EX_XLEN-1:0] opb;
	logic [SHAMT_W-1:0]  shamt;
	logic [`EX_XLEN-1:0] alu_out;
	logic [`EX_XLEN-1:0] br_target;
	logic [`EX_XLEN-1:0] rs1;
	logic [`EX_XLEN-1:0] rs2;
	logic                br_cond;

	assign opa   = op.opa;
	assign opb   = op.opb;
	assign shamt = opb[SHAMT_W-1:0];
	assign rs1   = op.pkt.rs1_value;
	assign rs2   = op.pkt.rs2_value;

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op.pkt.alu_func)
			ALU_ADD:  alu_out = opa + opb;
			ALU_SUB:  alu_out = opa - opb;
			ALU_AND:  alu_out = opa & opb;
			ALU_OR:   alu_out = opa | opb;
			ALU_XOR:  alu_out = opa ^ opb;
			ALU_SLT:  alu_out = {{(`EX_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
			ALU_SLTU: alu_out = {{(`EX_XLEN-1){1'b0}}, opa < opb};
			ALU_SLL:  alu_out = opa << shamt;
			ALU_SRL:  alu_out = opa >> shamt;
			ALU_SRA:  alu_out = $signed(opa) >>> shamt;
			// multiplies go to the lane pool
			default:  alu_out = '0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// branch condition and target
	////////////////////////////////////////////////////////////////////////////

	assign br_target = opa + opb;

	always_comb begin
		case (op.pkt.funct3)
			3'b000:  br_cond = (rs1 == rs2);
			3'b001:  br_cond = (rs1 != rs2);
			3'b100:  br_cond = ($signed(rs1) < $signed(rs2));
			3'b101:  br_cond = ($signed(rs1) >= $signed(rs2));
			3'b110:  br_cond = (rs1 < rs2);
			3'b111:  br_cond = (rs1 >= rs2);
			default: br_cond = 1'b0;
		endcase
	end

	// result packet
	assign result.valid       = alu_start | br_start;
	assign result.pc          = op.pkt.pc;
	assign result.pred_npc    = op.pkt.pred_npc;
	assign result.dest_tag    = op.pkt.dest_tag;
	assign result.result      = br_start ? br_target : alu_out;
	assign result.take_branch = br_start &
		(op.pkt.uncond_branch | (op.pkt.cond_branch & br_cond));
	assign result.is_branch   = br_start;

	// strobes come from the operand select decode
	always_comb begin
		assert #0 (!(alu_start && br_start))
			else $error("alu_start and br_start high together");
	end

endmodule

//--- ex_mul_lane.sv
/*
 * one fixed-latency multiplier lane; start latches the operands, done
 * pulses EX_MUL_CYCLES cycles later with the low or high product word
 */

`include "ex_macros.svh"

module ex_mul_lane
	import ex_pkg::*;
(
	input  logic           clock,
	input  logic           rst,
	input  logic           start,
	input  ex_op_t         op,
	output logic           busy,
	output logic           done,
	output ex_result_pkt_t result
);

	localparam int CNT_W = $clog2(`EX_MUL_CYCLES + 1);

	logic [CNT_W-1:0]             cnt;
	ex_op_t                       op_q;
	logic                         a_signed;
	logic                         b_signed;
	logic signed [`EX_XLEN:0]     a_ext;
	logic signed [`EX_XLEN:0]     b_ext;
	logic signed [2*`EX_XLEN+1:0] prod;

	assign done = busy && (cnt == '0);

	// countdown, a finishing lane may be restarted at once
	always_ff @(posedge clock) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= CNT_W'(`EX_MUL_CYCLES - 1);
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			op_q <= op;
	end

	// operand signedness per variant, MUL low word is the same either way
	always_comb begin
		case (op_q.pkt.alu_func)
			ALU_MULH: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			ALU_MULHSU: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
			end
			default: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
		endcase
	end

	assign a_ext = {a_signed & op_q.opa[`EX_XLEN-1], op_q.opa};
	assign b_ext = {b_signed & op_q.opb[`EX_XLEN-1], op_q.opb};
	assign prod  = a_ext * b_ext;

	assign result.valid       = done;
	assign result.pc          = op_q.pkt.pc;
	assign result.pred_npc    = op_q.pkt.pred_npc;
	assign result.dest_tag    = op_q.pkt.dest_tag;
	assign result.result      = (op_q.pkt.alu_func == ALU_MUL) ?
		prod[`EX_XLEN-1:0] : prod[2*`EX_XLEN-1:`EX_XLEN];
	assign result.take_branch = 1'b0;
	assign result.is_branch   = 1'b0;

	// pool must only pick an idle or finishing lane
	a_no_start_busy: assert property (@(posedge clock) disable iff (rst)
		start |-> (!busy || done))
		else $error("mul lane started while busy");

endmodule

//--- ex_mul_pool.sv
/*
 * pool of multiplier lanes; a start goes to the lowest free lane and
 * the result of whichever lane finishes is forwarded to the queue
 */

`include "ex_macros.svh"

module ex_mul_pool
	import ex_pkg::*;
(
	input  logic           clock,
	input  logic           rst,
	input  logic           mul_start,
	input  ex_op_t         op,
	output logic           mul_ready,
	output ex_result_pkt_t result
);

	logic [`EX_MUL_NUM-1:0] lane_busy;
	logic [`EX_MUL_NUM-1:0] lane_done;
	logic [`EX_MUL_NUM-1:0] lane_avail;
	logic [`EX_MUL_NUM-1:0] lane_start;
	ex_result_pkt_t         lane_res [`EX_MUL_NUM];
	logic                   found;

	// free now, or free after this edge
	assign lane_avail = ~lane_busy | lane_done;
	assign mul_ready  = |lane_avail;

	// lowest available lane wins
	always_comb begin
		lane_start = '0;
		found      = 1'b0;
		for (int i = 0; i < `EX_MUL_NUM; i++) begin
			if (lane_avail[i] && !found) begin
				lane_start[i] = mul_start;
				found         = 1'b1;
			end
		end
	end

	for (genvar i = 0; i < `EX_MUL_NUM; i++) begin : g_lane
		ex_mul_lane u_lane (
			.clock  (clock),
			.rst    (rst),
			.start  (lane_start[i]),
			.op     (op),
			.busy   (lane_busy[i]),
			.done   (lane_done[i]),
			.result (lane_res[i])
		);
	end

	// forward the finishing lane
	always_comb begin
		result = '0;
		for (int i = 0; i < `EX_MUL_NUM; i++) begin
			if (lane_done[i])
				result = lane_res[i];
		end
	end

	// lanes start on distinct cycles with equal latency
	a_one_done: assert property (@(posedge clock) disable iff (rst)
		$onehot0(lane_done))
		else $error("more than one mul lane done in a cycle");

endmodule

//--- ex_complete_queue.sv
/*
 * completion queue: takes the ALU/branch and the multiplier result each
 * edge (in that order), registers one entry per cycle to the output and
 * derives the predictor update and the correct-prediction flag
 */

`include "ex_macros.svh"

module ex_complete_queue
	import ex_pkg::*;
(
	input  logic           clock,
	input  logic           rst,
	input  ex_result_pkt_t alu_res,
	input  ex_result_pkt_t mul_res,
	output ex_result_pkt_t out_pkt,
	output logic           no_output,
	output logic           queue_ready,
	output logic           correct_predict,
	output ex_btb_upd_t    btb_upd
);

	localparam int PTR_W = $clog2(`EX_CQ_DEPTH);
	localparam int CNT_W = $clog2(`EX_CQ_DEPTH + 1) + 1;

	ex_result_pkt_t      mem [`EX_CQ_DEPTH];
	logic [PTR_W-1:0]    head;
	logic [PTR_W-1:0]    tail;
	logic [CNT_W-1:0]    count;
	logic                empty;
	ex_result_pkt_t      in_pkt [2];
	logic [1:0]          n_in;
	logic [1:0]          n_wr;
	logic [CNT_W-1:0]    count_next;
	logic [`EX_XLEN-1:0] actual_npc;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	// compact the incoming results, alu/branch first
	assign in_pkt[0] = alu_res.valid ? alu_res : mul_res;
	assign in_pkt[1] = mul_res;
	assign n_in      = {1'b0, alu_res.valid} + {1'b0, mul_res.valid};
	assign empty     = (count == '0);

	// empty queue bypasses the first incoming result to the output
	assign n_wr       = (empty && n_in != 2'd0) ? n_in - 2'd1 : n_in;
	assign count_next = count + CNT_W'(n_wr) - CNT_W'(!empty);

	always_ff @(posedge clock) begin
		if (empty) begin
			if (n_in == 2'd2)
				mem[tail] <= in_pkt[1];
		end else begin
			if (n_in != 2'd0)
				mem[tail] <= in_pkt[0];
			if (n_in == 2'd2)
				mem[tail + 1'b1] <= in_pkt[1];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (!empty)
				head <= head + 1'b1;
			tail  <= tail + PTR_W'(n_wr);
			count <= count_next;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		out_pkt <= empty ? in_pkt[0] : mem[head];
		if (rst)
			out_pkt.valid <= 1'b0;
	end

	assign no_output   = !out_pkt.valid;
	assign queue_ready = (CNT_W'(`EX_CQ_DEPTH) - count) >= CNT_W'(`EX_CQ_HEADROOM);

	// predictor update, branches only
	assign btb_upd.valid     = out_pkt.valid && out_pkt.is_branch;
	assign btb_upd.pc        = out_pkt.pc;
	assign btb_upd.target_pc = out_pkt.result;
	assign btb_upd.taken     = out_pkt.take_branch;

	assign actual_npc      = out_pkt.take_branch ? out_pkt.result : out_pkt.pc + 32'd4;
	assign correct_predict = !btb_upd.valid || (actual_npc == out_pkt.pred_npc);

	// issuer and mul pool together must respect the headroom
	a_no_overflow: assert property (@(posedge clock) disable iff (rst)
		count_next <= CNT_W'(`EX_CQ_DEPTH))
		else $error("completion queue overflow");

endmodule

//--- ex_stage.sv
/*
 * execute stage top: operand select, ALU/branch unit, multiplier pool
 * and completion queue; one issue packet in, one result packet out
 */

module ex_stage
	import ex_pkg::*;
(
	input  logic           clock,
	input  logic           rst,
	input  ex_issue_pkt_t  issue,
	output ex_result_pkt_t out_pkt,
	output logic           no_output,
	output logic           mul_ready,
	output logic           queue_ready,
	output logic           correct_predict,
	output ex_btb_upd_t    btb_upd
);

	ex_op_t         op;
	logic           alu_start;
	logic           br_start;
	logic           mul_start;
	ex_result_pkt_t alu_res;
	ex_result_pkt_t mul_res;

	// input side
	ex_operand_sel u_operand_sel (
		.issue     (issue),
		.op        (op),
		.alu_start (alu_start),
		.br_start  (br_start),
		.mul_start (mul_start)
	);

	// functional paths
	ex_alu_branch u_alu_branch (
		.op        (op),
		.alu_start (alu_start),
		.br_start  (br_start),
		.result    (alu_res)
	);

	ex_mul_pool u_mul_pool (
		.clock     (clock),
		.rst       (rst),
		.mul_start (mul_start),
		.op        (op),
		.mul_ready (mul_ready),
		.result    (mul_res)
	);

	// output side
	ex_complete_queue u_complete_queue (
		.clock           (clock),
		.rst             (rst),
		.alu_res         (alu_res),
		.mul_res         (mul_res),
		.out_pkt         (out_pkt),
		.no_output       (no_output),
		.queue_ready     (queue_ready),
		.correct_predict (correct_predict),
		.btb_upd         (btb_upd)
	);

endmodule

//--- tb_ex_stage.sv
/*
 * testbench for the execute stage that drives directed and random issue
 * packets and checks every output against a per-tag reference model
 * build and run with the Makefile next to list.f
 */

`include "ex_macros.svh"

module tb_ex_stage
	import ex_pkg::*;
();

	localparam int NUM_PKTS   = 61;
	localparam int RST_CYCLES = 5;
	localparam int TIMEOUT    = 20 * NUM_PKTS + RST_CYCLES;
	localparam int NTAGS      = 1 << `EX_TAG_W;

	logic           clock = 1'b0;
	logic           rst;
	ex_issue_pkt_t  issue;
	ex_result_pkt_t out_pkt;
	logic           no_output;
	logic           mul_ready;
	logic           queue_ready;
	logic           correct_predict;
	ex_btb_upd_t    btb_upd;

	// expected outcome per tag
	bit [`EX_XLEN-1:0]  exp_res  [NTAGS];
	bit [`EX_XLEN-1:0]  exp_pc   [NTAGS];
	bit                 exp_take [NTAGS];
	bit                 exp_br   [NTAGS];
	bit                 exp_pred [NTAGS];
	bit                 exp_mul  [NTAGS];
	int                 exp_lat  [NTAGS];
	int                 iss_cyc  [NTAGS];
	bit                 issued   [NTAGS];
	bit                 retired  [NTAGS];
	bit [`EX_TAG_W-1:0] alu_ord  [NTAGS];
	bit [`EX_TAG_W-1:0] mul_ord  [NTAGS];

	int alu_wr;
	int alu_rd;
	int mul_wr;
	int mul_rd;
	int issued_count;
	int out_count;
	int err_count;
	int cyc;
	int mul_low_run;
	bit saw_mul_low;
	bit mul_prev1;
	bit mul_prev2;

	ex_stage u_dut (
		.clock           (clock),
		.rst             (rst),
		.issue           (issue),
		.out_pkt         (out_pkt),
		.no_output       (no_output),
		.mul_ready       (mul_ready),
		.queue_ready     (queue_ready),
		.correct_predict (correct_predict),
		.btb_upd         (btb_upd)
	);

	always #5 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// reference rules
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [`EX_XLEN-1:0] opa_of(input ex_issue_pkt_t p);
		case (p.opa_sel)
			OPA_IS_RS1: return p.rs1_value;
			OPA_IS_PC:  return p.pc;
			default:    return '0;
		endcase
	endfunction

	function automatic logic [`EX_XLEN-1:0] opb_of(input ex_issue_pkt_t p);
		return (p.opb_sel == OPB_IS_IMM) ? p.imm : p.rs2_value;
	endfunction

	function automatic logic [`EX_XLEN-1:0] alu_ref(input ex_alu_func_e f,
		input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
		case (f)
			ALU_ADD:  return a + b;
			ALU_SUB:  return a - b;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
			ALU_SLTU: return (a < b) ? 1 : 0;
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
			default:  return '0;
		endcase
	endfunction

	// MUL returns the low product word and the others the high word
	function automatic logic [`EX_XLEN-1:0] mul_ref(input ex_alu_func_e f,
		input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
		longint          sa;
		longint          sb;
		longint unsigned ua;
		longint unsigned ub;
		longint unsigned prod;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = {32'b0, a};
		ub = {32'b0, b};
		case (f)
			ALU_MULH:   prod = $unsigned(sa * sb);
			ALU_MULHSU: prod = $unsigned(sa * longint'(ub));
			default:    prod = ua * ub;
		endcase
		return (f == ALU_MUL) ? prod[31:0] : prod[63:32];
	endfunction

	function automatic logic taken_ref(input ex_issue_pkt_t p);
		logic lt;
		logic ltu;
		logic c;
		lt  = $signed(p.rs1_value) < $signed(p.rs2_value);
		ltu = p.rs1_value < p.rs2_value;
		case (p.funct3)
			3'b000:  c = (p.rs1_value == p.rs2_value);
			3'b001:  c = (p.rs1_value != p.rs2_value);
			3'b100:  c = lt;
			3'b101:  c = !lt;
			3'b110:  c = ltu;
			3'b111:  c = !ltu;
			default: c = 1'b0;
		endcase
		return p.uncond_branch || (p.cond_branch && c);
	endfunction

	function automatic logic [`EX_XLEN-1:0] actual_npc(input ex_issue_pkt_t p);
		return taken_ref(p) ? opa_of(p) + opb_of(p) : p.pc + 32'd4;
	endfunction

	function automatic logic [2:0] br_f3(input int i);
		case (i)
			0:       return 3'b000;
			1:       return 3'b001;
			2:       return 3'b100;
			3:       return 3'b101;
			4:       return 3'b110;
			default: return 3'b111;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic ex_issue_pkt_t make_pkt(input ex_channel_e chan,
		input ex_alu_func_e func, input logic [2:0] f3, input logic uncond);
		ex_issue_pkt_t     p;
		logic [`EX_XLEN-1:0] r;
		p             = '0;
		r             = $urandom();
		p.valid       = 1'b1;
		p.channel     = chan;
		p.alu_func    = func;
		p.funct3      = f3;
		p.pc          = $urandom() & 32'hffff_fffc;
		p.rs1_value   = $urandom();
		p.rs2_value   = ($urandom_range(0, 3) == 0) ? p.rs1_value : $urandom();
		p.imm         = {{(`EX_XLEN-12){r[11]}}, r[11:0]};
		if (chan == BR) begin
			p.opa_sel       = OPA_IS_PC;
			p.opb_sel       = OPB_IS_IMM;
			p.cond_branch   = !uncond;
			p.uncond_branch = uncond;
			p.pred_npc      = actual_npc(p);
			// mispredict about half of them
			if ($urandom_range(0, 1) == 1)
				p.pred_npc = p.pred_npc + 32'd8;
		end else begin
			p.opa_sel  = ex_opa_sel_e'($urandom_range(0, 2));
			p.opb_sel  = ex_opb_sel_e'($urandom_range(0, 1));
			p.pred_npc = p.pc + 32'd4;
		end
		return p;
	endfunction

	function automatic ex_issue_pkt_t random_pkt();
		int unsigned r;
		r = $urandom_range(0, 9);
		if (r < 4)
			return make_pkt(ALU, ex_alu_func_e'($urandom_range(0, 9)), 3'b000, 1'b0);
		else if (r < 7)
			return make_pkt(BR, ALU_ADD, br_f3($urandom_range(0, 5)),
				$urandom_range(0, 5) == 0);
		else
			return make_pkt(MULT, ex_alu_func_e'(10 + $urandom_range(0, 3)), 3'b000, 1'b0);
	endfunction

	task automatic record(input ex_issue_pkt_t p, input int lat);
		logic [`EX_XLEN-1:0] res;
		logic                take;
		take = 1'b0;
		case (p.channel)
			BR: begin
				res  = opa_of(p) + opb_of(p);
				take = taken_ref(p);
			end
			MULT:    res = mul_ref(p.alu_func, opa_of(p), opb_of(p));
			default: res = alu_ref(p.alu_func, opa_of(p), opb_of(p));
		endcase
		exp_res[p.dest_tag]  <= res;
		exp_pc[p.dest_tag]   <= p.pc;
		exp_take[p.dest_tag] <= take;
		exp_br[p.dest_tag]   <= (p.channel == BR);
		exp_pred[p.dest_tag] <= (p.channel != BR) || (actual_npc(p) == p.pred_npc);
		exp_mul[p.dest_tag]  <= (p.channel == MULT);
		exp_lat[p.dest_tag]  <= lat;
		iss_cyc[p.dest_tag]  <= cyc + 1;
		issued[p.dest_tag]   <= 1'b1;
		issued_count         <= issued_count + 1;
		if (p.channel == MULT) begin
			mul_ord[mul_wr] <= p.dest_tag;
			mul_wr          <= mul_wr + 1;
		end else begin
			alu_ord[alu_wr] <= p.dest_tag;
			alu_wr          <= alu_wr + 1;
		end
	endtask

	// two back-to-back multiplies fill both lanes, so a third has to wait
	task automatic send(input ex_issue_pkt_t p, input int lat);
		bit ok;
		ok = 1'b0;
		while (!ok) begin
			@(posedge clock);
			ok = queue_ready &&
				(p.channel != MULT || (mul_ready && !(mul_prev1 && mul_prev2)));
			mul_prev2 = mul_prev1;
			mul_prev1 = ok && (p.channel == MULT);
			if (ok) begin
				p.dest_tag = issued_count[`EX_TAG_W-1:0];
				issue <= p;
				record(p, lat);
			end else begin
				issue <= '0;
			end
		end
	endtask

	task automatic idle_cycle();
		@(posedge clock);
		issue     <= '0;
		mul_prev2  = mul_prev1;
		mul_prev1  = 1'b0;
	endtask

	task automatic drain();
		idle_cycle();
		while (out_count != issued_count)
			idle_cycle();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////////////////////

	task automatic flag_error(input string msg);
		err_count++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	logic [`EX_TAG_W-1:0] t;
	logic res_ok;
	logic br_ok;
	logic btb_ok;
	logic pred_ok;
	logic once_ok;
	logic order_ok;
	logic lat_ok;
	logic idle_ok;

	assign t = out_pkt.dest_tag;

	always_comb begin
		res_ok   = (out_pkt.result == exp_res[t]);
		br_ok    = (out_pkt.take_branch == exp_take[t]) && (out_pkt.is_branch == exp_br[t]);
		btb_ok   = exp_br[t] ? (btb_upd.valid && btb_upd.pc == exp_pc[t] &&
			btb_upd.target_pc == exp_res[t] && btb_upd.taken == exp_take[t]) : !btb_upd.valid;
		pred_ok  = (correct_predict == exp_pred[t]);
		once_ok  = issued[t] && !retired[t];
		order_ok = exp_mul[t] ? (mul_ord[mul_rd] == t) : (alu_ord[alu_rd] == t);
		lat_ok   = (exp_lat[t] == 0) || (cyc - iss_cyc[t] == exp_lat[t]);
		idle_ok  = (issued_count != out_count) ||
			(no_output && !out_pkt.valid && !btb_upd.valid && mul_ready && queue_ready);
	end

	a_result: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> res_ok)
		else flag_error("result value differs from reference");
	a_branch: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> br_ok)
		else flag_error("take_branch or is_branch differs from reference");
	a_btb: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> btb_ok)
		else flag_error("btb update differs from reference");
	a_predict: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> pred_ok)
		else flag_error("correct_predict differs from reference");
	a_once: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> once_ok)
		else flag_error("tag not pending at output");
	a_order: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> order_ok)
		else flag_error("result out of issue order");
	a_latency: assert property (@(posedge clock) disable iff (rst) out_pkt.valid |-> lat_ok)
		else flag_error("wrong latency on idle queue");
	a_no_output: assert property (@(posedge clock) disable iff (rst)
		out_pkt.valid |-> !no_output)
		else flag_error("no_output high while a result is valid");
	a_idle: assert property (@(posedge clock) disable iff (rst) idle_ok)
		else flag_error("outputs not idle with nothing pending");
	a_mul_recover: assert property (@(posedge clock) disable iff (rst)
		mul_low_run <= `EX_MUL_CYCLES)
		else flag_error("mul_ready stuck low");
	a_mul_issue: assert property (@(posedge clock) disable iff (rst)
		(issue.valid && issue.channel == MULT) |-> mul_ready)
		else flag_error("multiply issued while mul_ready low");

	// retire bookkeeping
	always @(posedge clock) begin
		if (rst) begin
			mul_low_run <= 0;
		end else begin
			mul_low_run <= mul_ready ? 0 : mul_low_run + 1;
			if (!mul_ready)
				saw_mul_low <= 1'b1;
			if (out_pkt.valid) begin
				retired[t] <= 1'b1;
				out_count  <= out_count + 1;
				if (exp_mul[t])
					mul_rd <= mul_rd + 1;
				else
					alu_rd <= alu_rd + 1;
			end
		end
	end

	always @(posedge clock) begin
		if (cyc >= TIMEOUT) begin
			$display("timeout after %0d cycles, %0d of %0d results seen",
				cyc, out_count, issued_count);
			$display("*** FAILED ***");
			$finish;
		end else begin
			cyc <= cyc + 1;
		end
	end

	initial begin
		void'($urandom(79610));
		rst   = 1'b1;
		issue = '0;
		repeat (RST_CYCLES) @(posedge clock);
		rst <= 1'b0;

		// one at a time on an idle queue
		for (int f = 0; f < 10; f++) begin
			send(make_pkt(ALU, ex_alu_func_e'(f), 3'b000, 1'b0), 1);
			drain();
		end
		for (int i = 0; i < 6; i++) begin
			send(make_pkt(BR, ALU_ADD, br_f3(i), 1'b0), 1);
			drain();
		end
		send(make_pkt(BR, ALU_ADD, 3'b000, 1'b1), 1);
		drain();
		for (int f = 10; f < 14; f++) begin
			send(make_pkt(MULT, ex_alu_func_e'(f), 3'b000, 1'b0), `EX_MUL_CYCLES + 1);
			drain();
		end

		// multiply burst that fills both lanes
		for (int k = 0; k < 4; k++)
			send(make_pkt(MULT, ex_alu_func_e'(10 + k), 3'b000, 1'b0), 0);
		drain();

		// random mix issued back to back
		for (int n = 0; n < 36; n++)
			send(random_pkt(), 0);
		drain();

		if (!saw_mul_low) begin
			err_count++;
			$display("mul_ready never went low during the multiply burst");
		end
		$display("packets %0d, results %0d, errors %0d", issued_count, out_count, err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- list.f
+incdir+.
ex_pkg.sv
ex_operand_sel.sv
ex_alu_branch.sv
ex_mul_lane.sv
ex_mul_pool.sv
ex_complete_queue.sv
ex_stage.sv
tb_ex_stage.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

.PHONY: run clean

run: obj_dir/Vtb_ex_stage
	@out="$$(./obj_dir/Vtb_ex_stage)"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

obj_dir/Vtb_ex_stage: list.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_ex_stage -f list.f

clean:
	rm -rf obj_dir
